/* logic/trc_params.svh */
`ifndef TRC_PARAMS_SVH
`define TRC_PARAMS_SVH

// widths
`define TRC_PC_W        16
`define TRC_INS_W       32

// geometry of the line store
`define TRC_LINES       8
`define TRC_SLOTS       4

// use counts and decay
`define TRC_USE_MAX     7
`define TRC_USE_FILL    2
`define TRC_DECAY_BASE  16

`endif

/* logic/trc_pkg.sv */
`include "trc_params.svh"

package trc_pkg;

        typedef logic [`TRC_PC_W-1:0]          pc_t;
        typedef logic [`TRC_INS_W-1:0]         ins_t;
        typedef logic [$clog2(`TRC_LINES)-1:0] line_t;
        typedef logic [$clog2(`TRC_SLOTS)-1:0] slot_t;
        typedef logic [`TRC_SLOTS-1:0]         mask_t;
        typedef logic [2:0]                    use_t;

        // flat data array address, line above slot
        typedef logic [$bits(line_t)+$bits(slot_t)-1:0] addr_t;

        // a jump closes the trace
        typedef enum logic [2:0] {
                UNIT_ALU,
                UNIT_LOAD,
                UNIT_STORE,
                UNIT_BRANCH,
                UNIT_JUMP
        } unit_e;

        typedef enum logic [1:0] {FILL_IDLE, FILL_COLLECT, FILL_WRITE} fill_state_e;

        typedef enum logic {LOOK_IDLE, LOOK_STREAM} look_state_e;

endpackage

/* logic/trc_meta.sv */
`timescale 1ns/1ns
`include "trc_params.svh"

module trc_meta import trc_pkg::*; (
        input  logic       clk,
        input  logic       arst_n,
        input  logic       trace_enable,
        input  logic [1:0] trace_scale,
        input  logic       invalidate,
        input  logic [3:0] cpu_mode,
        input  pc_t        query_pc,
        input  logic       hit_use,
        input  pc_t        probe_pc,
        input  logic       commit,
        input  line_t      commit_line,
        input  pc_t        commit_tag,
        input  mask_t      commit_mask,
        input  pc_t        commit_next,
        output logic       query_hit,
        output line_t      query_line,
        output mask_t      query_mask,
        output pc_t        query_next,
        output logic       probe_present,
        output logic       victim_valid,
        output line_t      victim_line
);

        localparam int DECAY_W = $clog2(`TRC_DECAY_BASE) + 4;

        pc_t   tag     [`TRC_LINES];
        pc_t   next_pc [`TRC_LINES];
        mask_t valid   [`TRC_LINES];
        use_t  use_cnt [`TRC_LINES];

        logic [3:0]         mode_q;
        logic [DECAY_W-1:0] decay_cnt;
        logic               flush;
        logic               decay_tick;

        // pin, mode change or disable all drop every line
        assign flush = invalidate || cpu_mode != mode_q || !trace_enable;
        assign decay_tick = decay_cnt == '0;

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        mode_q    <= '0;
                        decay_cnt <= '0;
                end else begin
                        mode_q <= cpu_mode;
                        // period doubles with each scale step
                        if (flush || decay_tick)
                                decay_cnt <= (DECAY_W'(`TRC_DECAY_BASE) << trace_scale) - 1'b1;
                        else
                                decay_cnt <= decay_cnt - 1'b1;
                end
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        for (int i = 0; i < `TRC_LINES; i++) begin
                                valid[i]   <= '0;
                                use_cnt[i] <= '0;
                        end
                end else if (flush) begin
                        for (int i = 0; i < `TRC_LINES; i++) begin
                                valid[i]   <= '0;
                                use_cnt[i] <= '0;
                        end
                end else begin
                        for (int i = 0; i < `TRC_LINES; i++) begin
                                if (commit && commit_line == line_t'(i)) begin
                                        valid[i]   <= commit_mask;
                                        use_cnt[i] <= use_t'(`TRC_USE_FILL);
                                end else if (hit_use && query_line == line_t'(i)) begin
                                        if (use_cnt[i] != use_t'(`TRC_USE_MAX))
                                                use_cnt[i] <= use_cnt[i] + 1'b1;
                                end else if (decay_tick && use_cnt[i] != '0) begin
                                        use_cnt[i] <= use_cnt[i] - 1'b1;
                                        // line is released once its count runs out
                                        if (use_cnt[i] == use_t'(1))
                                                valid[i] <= '0;
                                end
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (commit) begin
                        tag[commit_line]     <= commit_tag;
                        next_pc[commit_line] <= commit_next;
                end
        end

        always_comb begin
                query_hit     = 1'b0;
                query_line    = '0;
                probe_present = 1'b0;
                victim_valid  = 1'b0;
                victim_line   = '0;
                // scan downwards so the lowest line wins
                for (int i = `TRC_LINES - 1; i >= 0; i--) begin
                        if (valid[i][0] && tag[i] == query_pc) begin
                                query_hit  = 1'b1;
                                query_line = line_t'(i);
                        end
                        if (valid[i][0] && tag[i] == probe_pc)
                                probe_present = 1'b1;
                        if (use_cnt[i] == '0) begin
                                victim_valid = 1'b1;
                                victim_line  = line_t'(i);
                        end
                end
        end

        assign query_mask = valid[query_line];
        assign query_next = next_pc[query_line];

        // the line picked at the end of collection must still be free at commit
        a_commit_free: assert property (@(posedge clk) disable iff (!arst_n)
                commit |-> use_cnt[commit_line] == '0);

endmodule

/* logic/trc_fill.sv */
`timescale 1ns/1ns
`include "trc_params.svh"

module trc_fill import trc_pkg::*; (
        input  logic  clk,
        input  logic  arst_n,
        input  logic  trace_enable,
        input  logic  ret_valid,
        input  pc_t   ret_pc,
        input  ins_t  ret_ins,
        input  unit_e ret_unit,
        input  logic  ret_start,
        input  logic  ret_trap,
        input  pc_t   ret_next,
        input  logic  probe_present,
        input  logic  victim_valid,
        input  line_t victim_line,
        input  logic  grant,
        output pc_t   probe_pc,
        output logic  req,
        output line_t line,
        output slot_t slot,
        output ins_t  data,
        output logic  commit,
        output line_t commit_line,
        output pc_t   commit_tag,
        output mask_t commit_mask,
        output pc_t   commit_next
);

        fill_state_e state;

        ins_t  ins_q [`TRC_SLOTS];
        pc_t   tag_q;
        pc_t   next_q;
        mask_t mask_q;
        line_t line_q;
        slot_t cnt;
        slot_t last_q;
        slot_t wr_slot;
        logic  store;
        logic  done;
        logic  abort;

        assign probe_pc = ret_pc;

        // instruction joins a trace, a new one only at a start point not yet cached
        assign store = ret_valid && !ret_trap && trace_enable &&
                       (state == FILL_COLLECT ||
                        (state == FILL_IDLE && ret_start && !probe_present));

        // jump or full line closes the trace
        assign done = ret_unit == UNIT_JUMP || cnt == slot_t'(`TRC_SLOTS - 1);

        assign abort = state == FILL_COLLECT && (!trace_enable || (ret_valid && ret_trap));

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        state   <= FILL_IDLE;
                        cnt     <= '0;
                        wr_slot <= '0;
                        mask_q  <= '0;
                end else begin
                        case (state)
                        FILL_IDLE, FILL_COLLECT: begin
                                if (abort) begin
                                        state <= FILL_IDLE;
                                        cnt   <= '0;
                                end else if (store) begin
                                        mask_q <= (state == FILL_IDLE ? mask_t'(0) : mask_q) |
                                                  (mask_t'(1) << cnt);
                                        cnt    <= done ? '0 : cnt + 1'b1;
                                        // without a free line the trace is dropped
                                        if (done)
                                                state <= victim_valid ? FILL_WRITE : FILL_IDLE;
                                        else
                                                state <= FILL_COLLECT;
                                end
                        end
                        FILL_WRITE: begin
                                if (commit) begin
                                        state   <= FILL_IDLE;
                                        wr_slot <= '0;
                                end else if (grant) begin
                                        wr_slot <= wr_slot + 1'b1;
                                end
                        end
                        default: state <= FILL_IDLE;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (store) begin
                        ins_q[cnt] <= ret_ins;
                        next_q     <= ret_next;
                        last_q     <= cnt;
                        if (state == FILL_IDLE)
                                tag_q <= ret_pc;
                        if (done)
                                line_q <= victim_line;
                end
        end

        // one slot per granted cycle, commit with the last one
        assign req  = state == FILL_WRITE;
        assign line = line_q;
        assign slot = wr_slot;
        assign data = ins_q[wr_slot];

        assign commit      = req && grant && wr_slot == last_q;
        assign commit_line = line_q;
        assign commit_tag  = tag_q;
        assign commit_mask = mask_q;
        assign commit_next = next_q;

endmodule

/* logic/trc_lookup.sv */
`timescale 1ns/1ns
`include "trc_params.svh"

module trc_lookup import trc_pkg::*; (
        input  logic  clk,
        input  logic  arst_n,
        input  logic  fetch_valid,
        input  pc_t   fetch_pc,
        input  logic  stall,
        input  logic  query_hit,
        input  line_t query_line,
        input  mask_t query_mask,
        input  pc_t   query_next,
        input  logic  grant,
        input  ins_t  rdata,
        output logic  fetch_ready,
        output pc_t   query_pc,
        output logic  hit_use,
        output logic  req,
        output line_t line,
        output slot_t slot,
        output logic  resp_valid,
        output logic  resp_hit,
        output ins_t  resp_ins,
        output logic  resp_last,
        output pc_t   resp_next_pc
);

        look_state_e state;

        line_t cur_line;
        slot_t rd_slot;
        slot_t last_slot;
        slot_t query_last;
        logic  accept;

        // highest valid slot of the matching line
        always_comb begin
                query_last = '0;
                for (int i = 0; i < `TRC_SLOTS; i++) begin
                        if (query_mask[i])
                                query_last = slot_t'(i);
                end
        end

        assign fetch_ready = state == LOOK_IDLE && !stall;
        assign accept      = fetch_valid && fetch_ready;
        assign query_pc    = fetch_pc;
        assign hit_use     = accept && query_hit;

        // slot 0 is read in the accept cycle, the rest one per unstalled cycle
        assign req  = hit_use || (state == LOOK_STREAM && !stall && !resp_last);
        assign line = state == LOOK_IDLE ? query_line : cur_line;
        assign slot = state == LOOK_IDLE ? '0 : rd_slot;

        // the memory read register is the presented word
        assign resp_ins = rdata;

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        state      <= LOOK_IDLE;
                        rd_slot    <= '0;
                        resp_valid <= 1'b0;
                        resp_hit   <= 1'b0;
                        resp_last  <= 1'b0;
                end else if (!stall) begin
                        case (state)
                        LOOK_IDLE: begin
                                resp_valid <= accept;
                                resp_hit   <= query_hit;
                                resp_last  <= !query_hit || query_last == '0;
                                rd_slot    <= slot_t'(1);
                                if (hit_use)
                                        state <= LOOK_STREAM;
                        end
                        LOOK_STREAM: begin
                                if (resp_last) begin
                                        // last beat taken
                                        state      <= LOOK_IDLE;
                                        resp_valid <= 1'b0;
                                end else if (grant) begin
                                        resp_last <= rd_slot == last_slot;
                                        rd_slot   <= rd_slot + 1'b1;
                                end
                        end
                        default: state <= LOOK_IDLE;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (hit_use) begin
                        cur_line  <= query_line;
                        last_slot <= query_last;
                end
                // a miss hands back the fetch pc
                if (accept)
                        resp_next_pc <= query_hit ? query_next : fetch_pc;
        end

        // outside a stream only a miss beat is ever presented
        a_idle_miss: assert property (@(posedge clk) disable iff (!arst_n)
                (state == LOOK_IDLE && resp_valid) |-> (!resp_hit && resp_last));

endmodule

/* logic/trc_arbiter.sv */
`timescale 1ns/1ns

module trc_arbiter import trc_pkg::*; (
        input  logic  look_req,
        input  line_t look_line,
        input  slot_t look_slot,
        input  logic  fill_req,
        input  line_t fill_line,
        input  slot_t fill_slot,
        input  ins_t  fill_data,
        output logic  look_grant,
        output logic  fill_grant,
        output logic  mem_en,
        output logic  mem_we,
        output addr_t mem_addr,
        output ins_t  mem_wdata
);

        // lookup always wins, the fill write waits
        assign look_grant = look_req;
        assign fill_grant = fill_req && !look_req;

        assign mem_en    = look_req || fill_req;
        assign mem_we    = fill_grant;
        assign mem_addr  = look_req ? {look_line, look_slot} : {fill_line, fill_slot};
        assign mem_wdata = fill_data;

        always_comb begin
                a_one_grant: assert (!(look_grant && fill_grant))
                        else $error("data port granted to both requesters");
        end

endmodule

/* logic/trc_data_mem.sv */
`timescale 1ns/1ns
`include "trc_params.svh"

module trc_data_mem import trc_pkg::*; (
        input  logic  clk,
        input  logic  mem_en,
        input  logic  mem_we,
        input  addr_t mem_addr,
        input  ins_t  mem_wdata,
        output ins_t  rdata
);

        ins_t mem [`TRC_LINES * `TRC_SLOTS];

        // read register only moves on an enabled read
        always_ff @(posedge clk) begin
                if (mem_en) begin
                        if (mem_we)
                                mem[mem_addr] <= mem_wdata;
                        else
                                rdata <= mem[mem_addr];
                end
        end

endmodule

/* logic/trc_top.sv */
`timescale 1ns/1ns

module trc_top import trc_pkg::*; (
        input  logic       clk,
        input  logic       arst_n,
        input  logic       trace_enable,
        input  logic [1:0] trace_scale,
        input  logic       invalidate,
        input  logic [3:0] cpu_mode,
        input  logic       stall,
        input  logic       ret_valid,
        input  pc_t        ret_pc,
        input  ins_t       ret_ins,
        input  unit_e      ret_unit,
        input  logic       ret_start,
        input  logic       ret_trap,
        input  pc_t        ret_next,
        input  logic       fetch_valid,
        input  pc_t        fetch_pc,
        output logic       fetch_ready,
        output logic       resp_valid,
        output logic       resp_hit,
        output ins_t       resp_ins,
        output logic       resp_last,
        output pc_t        resp_next_pc
);

        // meta query and fill probe
        pc_t   query_pc;
        logic  query_hit;
        line_t query_line;
        mask_t query_mask;
        pc_t   query_next;
        logic  hit_use;
        pc_t   probe_pc;
        logic  probe_present;
        logic  victim_valid;
        line_t victim_line;

        // commit of a written trace
        logic  commit;
        line_t commit_line;
        pc_t   commit_tag;
        mask_t commit_mask;
        pc_t   commit_next;

        // data array port
        logic  look_req;
        logic  look_grant;
        line_t look_line;
        slot_t look_slot;
        logic  fill_req;
        logic  fill_grant;
        line_t fill_line;
        slot_t fill_slot;
        ins_t  fill_data;
        logic  mem_en;
        logic  mem_we;
        addr_t mem_addr;
        ins_t  mem_wdata;
        ins_t  rdata;

        trc_meta u_meta (
                .clk, .arst_n, .trace_enable, .trace_scale, .invalidate, .cpu_mode,
                .query_pc, .hit_use, .probe_pc,
                .commit, .commit_line, .commit_tag, .commit_mask, .commit_next,
                .query_hit, .query_line, .query_mask, .query_next,
                .probe_present, .victim_valid, .victim_line
        );

        trc_fill u_fill (
                .clk, .arst_n, .trace_enable,
                .ret_valid, .ret_pc, .ret_ins, .ret_unit, .ret_start, .ret_trap, .ret_next,
                .probe_present, .victim_valid, .victim_line,
                .grant(fill_grant),
                .probe_pc,
                .req(fill_req), .line(fill_line), .slot(fill_slot), .data(fill_data),
                .commit, .commit_line, .commit_tag, .commit_mask, .commit_next
        );

        trc_lookup u_lookup (
                .clk, .arst_n, .fetch_valid, .fetch_pc, .stall,
                .query_hit, .query_line, .query_mask, .query_next,
                .grant(look_grant), .rdata,
                .fetch_ready, .query_pc, .hit_use,
                .req(look_req), .line(look_line), .slot(look_slot),
                .resp_valid, .resp_hit, .resp_ins, .resp_last, .resp_next_pc
        );

        trc_arbiter u_arbiter (
                .look_req, .look_line, .look_slot,
                .fill_req, .fill_line, .fill_slot, .fill_data,
                .look_grant, .fill_grant,
                .mem_en, .mem_we, .mem_addr, .mem_wdata
        );

        trc_data_mem u_data_mem (
                .clk, .mem_en, .mem_we, .mem_addr, .mem_wdata, .rdata
        );

endmodule

/* verif/trc_tb.sv */
`timescale 1ns/1ns
`include "trc_params.svh"

module trc_tb import trc_pkg::*; ();

        localparam int  NTR = 16;
        // about 900 cycles of tests with the decay wait of the replacement test the largest part
        localparam int  TIMEOUT_CYCLES = 3000;
        // decay period with trace_scale at its maximum
        localparam int  DECAY_MAX = `TRC_DECAY_BASE << 3;
        localparam time DRIVE_DLY = 10;

        logic       clk;
        logic       arst_n;
        logic       trace_enable;
        logic [1:0] trace_scale;
        logic       invalidate;
        logic [3:0] cpu_mode;
        logic       stall;
        logic       ret_valid;
        pc_t        ret_pc;
        ins_t       ret_ins;
        unit_e      ret_unit;
        logic       ret_start;
        logic       ret_trap;
        pc_t        ret_next;
        logic       fetch_valid;
        pc_t        fetch_pc;
        logic       fetch_ready;
        logic       resp_valid;
        logic       resp_hit;
        ins_t       resp_ins;
        logic       resp_last;
        pc_t        resp_next_pc;

        // scoreboard of every trace the testbench retires
        pc_t   tr_pc     [NTR];
        ins_t  tr_ins    [NTR][`TRC_SLOTS];
        unit_e tr_unit   [NTR][`TRC_SLOTS];
        pc_t   tr_next   [NTR][`TRC_SLOTS];
        int    tr_len    [NTR];
        int    tr_trap   [NTR];
        bit    tr_cached [NTR];
        int    lines_used;

        logic [31:0] rng;
        int          errors;
        int          checks;
        int          cycles = 0;

        trc_top dut_i (
                .clk, .arst_n, .trace_enable, .trace_scale, .invalidate, .cpu_mode, .stall,
                .ret_valid, .ret_pc, .ret_ins, .ret_unit, .ret_start, .ret_trap, .ret_next,
                .fetch_valid, .fetch_pc, .fetch_ready,
                .resp_valid, .resp_hit, .resp_ins, .resp_last, .resp_next_pc
        );

        always #50 clk = ~clk;

        always @(posedge clk) begin
                cycles = cycles + 1;
                if (cycles >= TIMEOUT_CYCLES) begin
                        $display("timeout: the run did not finish within %0d cycles", cycles);
                        $display("Verification failed");
                        $finish;
                end
        end

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        task automatic check_val(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
                end
        endtask

        // inputs change a short delay after the rising edge
        task automatic step();
                @(posedge clk);
                #DRIVE_DLY;
        endtask

        task automatic flush_model();
                for (int i = 0; i < NTR; i++)
                        tr_cached[i] = 1'b0;
                lines_used = 0;
        endtask

        task automatic build_trace(input int t, input pc_t pc, input int len,
                                   input bit jump_end, input int trap_at);
                tr_pc[t]     = pc;
                tr_len[t]    = len;
                tr_trap[t]   = trap_at;
                tr_cached[t] = 1'b0;
                for (int i = 0; i < len; i++) begin
                        rng = xorshift32(rng);
                        tr_ins[t][i]  = rng;
                        tr_unit[t][i] = (jump_end && i == len - 1) ? UNIT_JUMP
                                                                   : unit_e'(rng[1:0]);
                        // a jump leaves the straight line
                        tr_next[t][i] = (tr_unit[t][i] == UNIT_JUMP) ? (pc ^ 16'h4000)
                                                                     : (pc + pc_t'(4 * (i + 1)));
                end
        endtask

        task automatic retire_trace(input int t);
                for (int i = 0; i < tr_len[t]; i++) begin
                        ret_valid = 1'b1;
                        ret_pc    = tr_pc[t] + pc_t'(4 * i);
                        ret_ins   = tr_ins[t][i];
                        ret_unit  = tr_unit[t][i];
                        ret_start = i == 0;
                        ret_trap  = i == tr_trap[t];
                        ret_next  = tr_next[t][i];
                        step();
                end
                ret_valid = 1'b0;
                ret_start = 1'b0;
                ret_trap  = 1'b0;
                // one write per cycle with the data port otherwise idle
                repeat (`TRC_SLOTS + 2) step();
                // only a trace closed by a full line or a jump is written
                if (tr_trap[t] < 0 && lines_used < `TRC_LINES &&
                    (tr_len[t] == `TRC_SLOTS || tr_unit[t][tr_len[t] - 1] == UNIT_JUMP)) begin
                        tr_cached[t] = 1'b1;
                        lines_used++;
                end
        endtask

        // fetch a trace pc and check every beat with an optional stall at one beat
        task automatic fetch_check(input int t, input int stall_at, input int stall_len);
                int k;
                int n;
                int hold;
                bit done;
                bit hit;
                k    = 0;
                n    = tr_len[t];
                hold = stall_len;
                done = 1'b0;
                hit  = tr_cached[t];
                fetch_valid = 1'b1;
                fetch_pc    = tr_pc[t];
                while (!fetch_ready)
                        step();
                step();
                fetch_valid = 1'b0;
                while (!done) begin
                        check_val("resp_valid", 32'(resp_valid), 32'd1);
                        check_val("resp_hit", 32'(resp_hit), 32'(hit));
                        if (hit) begin
                                check_val("resp_ins", resp_ins, tr_ins[t][k]);
                                check_val("resp_last", 32'(resp_last), 32'(k == n - 1));
                                if (k == n - 1)
                                        check_val("resp_next_pc", 32'(resp_next_pc),
                                                  32'(tr_next[t][n - 1]));
                        end else begin
                                check_val("resp_last", 32'(resp_last), 32'd1);
                        end
                        if (k == stall_at && hold > 0) begin
                                stall = 1'b1;
                                hold--;
                        end else begin
                                stall = 1'b0;
                                done  = !hit || k == n - 1;
                                k++;
                        end
                        step();
                end
                // nothing after the last beat
                check_val("resp_valid", 32'(resp_valid), 32'd0);
        endtask

        task automatic invalidate_cache();
                invalidate = 1'b1;
                step();
                invalidate = 1'b0;
                flush_model();
        endtask

        task automatic change_mode(input logic [3:0] mode);
                cpu_mode = mode;
                step();
                flush_model();
        endtask

        task automatic cold_fetch_misses();
                build_trace(0, 16'h1000, 4, 1'b0, -1);
                fetch_check(0, -1, 0);
        endtask

        task automatic full_trace_hits();
                invalidate_cache();
                build_trace(1, 16'h1100, 4, 1'b0, -1);
                retire_trace(1);
                fetch_check(1, -1, 0);
        endtask

        task automatic jump_and_trap_traces();
                invalidate_cache();
                build_trace(2, 16'h1200, 2, 1'b1, -1);
                build_trace(3, 16'h1300, 4, 1'b0, 2);
                retire_trace(2);
                retire_trace(3);
                fetch_check(2, -1, 0);
                fetch_check(3, -1, 0);
        endtask

        task automatic stall_holds_beats();
                invalidate_cache();
                build_trace(4, 16'h1400, 4, 1'b0, -1);
                retire_trace(4);
                fetch_check(4, 1, 3);
        endtask

        task automatic replacement_by_use();
                invalidate_cache();
                for (int i = 0; i < `TRC_LINES + 1; i++) begin
                        build_trace(5 + i, 16'h2000 + pc_t'(i * 256), 4, 1'b0, -1);
                        retire_trace(5 + i);
                end
                for (int i = 0; i < `TRC_LINES + 1; i++)
                        fetch_check(5 + i, -1, 0);
                // every use count has decayed to zero by now
                repeat (4 * DECAY_MAX + 16) step();
                flush_model();
                retire_trace(5 + `TRC_LINES);
                fetch_check(5 + `TRC_LINES, -1, 0);
        endtask

        task automatic flush_sources_miss();
                invalidate_cache();
                build_trace(14, 16'h3000, 3, 1'b1, -1);
                retire_trace(14);
                fetch_check(14, -1, 0);
                invalidate_cache();
                fetch_check(14, -1, 0);
                retire_trace(14);
                fetch_check(14, -1, 0);
                change_mode(4'h5);
                fetch_check(14, -1, 0);
        endtask

        initial begin
                clk          = 1'b0;
                arst_n       = 1'b0;
                trace_enable = 1'b1;
                trace_scale  = 2'd3;
                invalidate   = 1'b0;
                cpu_mode     = 4'h0;
                stall        = 1'b0;
                ret_valid    = 1'b0;
                ret_pc       = '0;
                ret_ins      = '0;
                ret_unit     = UNIT_ALU;
                ret_start    = 1'b0;
                ret_trap     = 1'b0;
                ret_next     = '0;
                fetch_valid  = 1'b0;
                fetch_pc     = '0;
                rng          = 32'd35340;
                errors       = 0;
                checks       = 0;
                flush_model();

                repeat (4) @(posedge clk);
                #DRIVE_DLY;
                arst_n = 1'b1;
                check_val("fetch_ready", 32'(fetch_ready), 32'd1);
                check_val("resp_valid", 32'(resp_valid), 32'd0);

                cold_fetch_misses();
                full_trace_hits();
                jump_and_trap_traces();
                stall_holds_beats();
                replacement_by_use();
                flush_sources_miss();

                $display("%0d errors in %0d checks over %0d cycles", errors, checks, cycles);
                if (errors == 0)
                        $display("Verification passed");
                else
                        $display("Verification failed");
                $finish;
        end

endmodule

/* flist.f */
+incdir+logic
logic/trc_pkg.sv
logic/trc_meta.sv
logic/trc_fill.sv
logic/trc_lookup.sv
logic/trc_arbiter.sv
logic/trc_data_mem.sv
logic/trc_top.sv
verif/trc_tb.sv

/* Makefile */
# Verilator build and run of the trace cache testbench

VERILATOR ?= verilator
TOP       ?= trc_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# the log decides the result, a missing pass line fails the target
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
